//--- source/rr_pkg.sv
package rr_pkg;

   // AXI field widths
   localparam int ID_W   = 4;
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int LEN_W  = 8;
   localparam int SIZE_W = 3;
   localparam int STRB_W = DATA_W / 8;
   localparam int RESP_W = 2;

   // Channel indices, also the bitmap bit and slot order
   localparam int NUM_CH = 5;
   localparam int CH_AW  = 0;
   localparam int CH_W   = 1;
   localparam int CH_AR  = 2;
   localparam int CH_B   = 3;
   localparam int CH_R   = 4;

   // Payload widths per channel
   localparam int AW_W = ID_W + ADDR_W + LEN_W + SIZE_W;
   localparam int W_W  = ID_W + DATA_W + STRB_W + 1;
   localparam int AR_W = ID_W + ADDR_W + LEN_W + SIZE_W;
   localparam int B_W  = ID_W + RESP_W;
   localparam int R_W  = ID_W + DATA_W + RESP_W + 1;

   typedef int ch_table_t [NUM_CH];

   localparam ch_table_t CH_WIDTHS = '{AW_W, W_W, AR_W, B_W, R_W};

   // Sum of the widths of channels below n
   function automatic int sum_widths(int n);
      int sum;
      sum = 0;
      for (int i = 0; i < n; i++) begin
         sum += CH_WIDTHS[i];
      end
      return sum;
   endfunction

   function automatic int max_width();
      int w;
      w = 0;
      for (int i = 0; i < NUM_CH; i++) begin
         if (CH_WIDTHS[i] > w) begin
            w = CH_WIDTHS[i];
         end
      end
      return w;
   endfunction

   localparam int CH_MAX_W = max_width();

   // Slots packed in channel order from bit 0
   localparam ch_table_t CH_OFFSETS = '{sum_widths(CH_AW), sum_widths(CH_W),
                                        sum_widths(CH_AR), sum_widths(CH_B),
                                        sum_widths(CH_R)};

   // Record is {bitmap, payload slots}
   localparam int REC_PAYLOAD_W = sum_widths(NUM_CH);
   localparam int REC_MAP_LSB   = REC_PAYLOAD_W;
   localparam int REC_W         = NUM_CH + REC_PAYLOAD_W;

endpackage

//--- source/axi_channel_logger.sv
`timescale 1ns/1ns

module axi_channel_logger #(
   parameter int WIDTH = 8
) (
   input  logic             clk,
   input  logic             i_rst,
   // Source side
   input  logic             i_in_valid,
   input  logic [WIDTH-1:0] i_in_data,
   output logic             o_in_ready,
   // Destination side
   output logic             o_out_valid,
   output logic [WIDTH-1:0] o_out_data,
   input  logic             i_out_ready,
   // Log side
   output logic             o_logb_valid,
   output logic [WIDTH-1:0] o_logb_data,
   input  logic             i_stall
);

   logic             full_q;
   logic [WIDTH-1:0] data_q;
   logic             logb_q;
   logic             accept;

   // Room when empty or draining this cycle, never while stalled
   assign o_in_ready = !i_stall && (!full_q || i_out_ready);
   assign accept     = i_in_valid && o_in_ready;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         full_q <= 1'b0;
         logb_q <= 1'b0;
      end else begin
         // One pulse per accepted beat, a held beat is not logged again
         logb_q <= accept;
         if (accept) begin
            full_q <= 1'b1;
         end else if (i_out_ready) begin
            full_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= i_in_data;
      end
   end

   assign o_out_valid = full_q;
   assign o_out_data  = data_q;

   // Register holds the new beat in the pulse cycle
   assign o_logb_valid = logb_q;
   assign o_logb_data  = data_q;

endmodule

//--- source/log_flow_ctrl.sv
`timescale 1ns/1ns

module log_flow_ctrl #(
   parameter int LOG_DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       i_rst,
   input  logic [$clog2(LOG_DEPTH):0] i_count,
   output logic                       o_stall
);

   localparam int CNT_W = $clog2(LOG_DEPTH) + 1;

   // Leaves room for the 3 records still in the pipeline
   localparam logic [CNT_W-1:0] HI_MARK = CNT_W'(LOG_DEPTH - 4);
   localparam logic [CNT_W-1:0] LO_MARK = CNT_W'(LOG_DEPTH / 2);

   logic stall_q;

   // Hysteresis keeps the stall from toggling on every record
   always_ff @(posedge clk) begin
      if (i_rst) begin
         stall_q <= 1'b0;
      end else if (i_count >= HI_MARK) begin
         stall_q <= 1'b1;
      end else if (i_count <= LO_MARK) begin
         stall_q <= 1'b0;
      end
   end

   assign o_stall = stall_q;

endmodule

//--- source/log_record_packer.sv
`timescale 1ns/1ns

module log_record_packer (
   input  logic                             clk,
   input  logic                             i_rst,
   input  logic [rr_pkg::NUM_CH-1:0]        i_logb_valid,
   input  logic [rr_pkg::REC_PAYLOAD_W-1:0] i_logb_data,
   output logic                             o_rec_valid,
   output logic [rr_pkg::REC_W-1:0]         o_rec_data
);

   import rr_pkg::*;

   logic [REC_PAYLOAD_W-1:0] slot_mask;
   logic [REC_PAYLOAD_W-1:0] payload;
   logic                     rec_valid_q;
   logic [REC_W-1:0]         rec_data_q;

   // Per-slot enable from the bitmap
   for (genvar g = 0; g < NUM_CH; g++) begin : gen_mask
      assign slot_mask[CH_OFFSETS[g] +: CH_WIDTHS[g]] = {CH_WIDTHS[g]{i_logb_valid[g]}};
   end

   // Idle slots read as zero
   assign payload = i_logb_data & slot_mask;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         rec_valid_q <= 1'b0;
      end else begin
         rec_valid_q <= |i_logb_valid;
      end
   end

   // All beats of one cycle go into a single record
   always_ff @(posedge clk) begin
      if (|i_logb_valid) begin
         rec_data_q[REC_MAP_LSB +: NUM_CH]  <= i_logb_valid;
         rec_data_q[REC_PAYLOAD_W-1:0]      <= payload;
      end
   end

   assign o_rec_valid = rec_valid_q;
   assign o_rec_data  = rec_data_q;

endmodule

//--- source/log_fifo.sv
`timescale 1ns/1ns

module log_fifo #(
   parameter int LOG_DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       i_rst,
   // Write side, no full check
   input  logic                       i_wr_valid,
   input  logic [rr_pkg::REC_W-1:0]   i_wr_data,
   // Read side
   output logic                       o_rd_valid,
   output logic [rr_pkg::REC_W-1:0]   o_rd_data,
   input  logic                       i_rd_ready,
   output logic [$clog2(LOG_DEPTH):0] o_count
);

   import rr_pkg::*;

   localparam int PTR_W = $clog2(LOG_DEPTH);

   logic [REC_W-1:0] mem [LOG_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count_q;
   logic             wr_en;
   logic             rd_en;

   // Flow control upstream guarantees room
   assign wr_en = i_wr_valid;
   assign rd_en = o_rd_valid && i_rd_ready;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   // Head shows in the cycle after the first write
   assign o_rd_valid = (count_q != '0);
   assign o_rd_data  = mem[rd_ptr];
   assign o_count    = count_q;

endmodule

//--- source/axi_recorder_top.sv
`timescale 1ns/1ns

module axi_recorder_top #(
   parameter int LOG_DEPTH = 16
) (
   input  logic                         clk,
   input  logic                         i_rst,

   // Master side, driven by the external master
   input  logic                         i_m_awvalid,
   input  logic [rr_pkg::ID_W-1:0]      i_m_awid,
   input  logic [rr_pkg::ADDR_W-1:0]    i_m_awaddr,
   input  logic [rr_pkg::LEN_W-1:0]     i_m_awlen,
   input  logic [rr_pkg::SIZE_W-1:0]    i_m_awsize,
   output logic                         o_m_awready,
   input  logic                         i_m_wvalid,
   input  logic [rr_pkg::ID_W-1:0]      i_m_wid,
   input  logic [rr_pkg::DATA_W-1:0]    i_m_wdata,
   input  logic [rr_pkg::STRB_W-1:0]    i_m_wstrb,
   input  logic                         i_m_wlast,
   output logic                         o_m_wready,
   input  logic                         i_m_arvalid,
   input  logic [rr_pkg::ID_W-1:0]      i_m_arid,
   input  logic [rr_pkg::ADDR_W-1:0]    i_m_araddr,
   input  logic [rr_pkg::LEN_W-1:0]     i_m_arlen,
   input  logic [rr_pkg::SIZE_W-1:0]    i_m_arsize,
   output logic                         o_m_arready,
   output logic                         o_m_bvalid,
   output logic [rr_pkg::ID_W-1:0]      o_m_bid,
   output logic [rr_pkg::RESP_W-1:0]    o_m_bresp,
   input  logic                         i_m_bready,
   output logic                         o_m_rvalid,
   output logic [rr_pkg::ID_W-1:0]      o_m_rid,
   output logic [rr_pkg::DATA_W-1:0]    o_m_rdata,
   output logic [rr_pkg::RESP_W-1:0]    o_m_rresp,
   output logic                         o_m_rlast,
   input  logic                         i_m_rready,

   // Slave side, driven by the external slave
   output logic                         o_s_awvalid,
   output logic [rr_pkg::ID_W-1:0]      o_s_awid,
   output logic [rr_pkg::ADDR_W-1:0]    o_s_awaddr,
   output logic [rr_pkg::LEN_W-1:0]     o_s_awlen,
   output logic [rr_pkg::SIZE_W-1:0]    o_s_awsize,
   input  logic                         i_s_awready,
   output logic                         o_s_wvalid,
   output logic [rr_pkg::ID_W-1:0]      o_s_wid,
   output logic [rr_pkg::DATA_W-1:0]    o_s_wdata,
   output logic [rr_pkg::STRB_W-1:0]    o_s_wstrb,
   output logic                         o_s_wlast,
   input  logic                         i_s_wready,
   output logic                         o_s_arvalid,
   output logic [rr_pkg::ID_W-1:0]      o_s_arid,
   output logic [rr_pkg::ADDR_W-1:0]    o_s_araddr,
   output logic [rr_pkg::LEN_W-1:0]     o_s_arlen,
   output logic [rr_pkg::SIZE_W-1:0]    o_s_arsize,
   input  logic                         i_s_arready,
   input  logic                         i_s_bvalid,
   input  logic [rr_pkg::ID_W-1:0]      i_s_bid,
   input  logic [rr_pkg::RESP_W-1:0]    i_s_bresp,
   output logic                         o_s_bready,
   input  logic                         i_s_rvalid,
   input  logic [rr_pkg::ID_W-1:0]      i_s_rid,
   input  logic [rr_pkg::DATA_W-1:0]    i_s_rdata,
   input  logic [rr_pkg::RESP_W-1:0]    i_s_rresp,
   input  logic                         i_s_rlast,
   output logic                         o_s_rready,

   // Log port
   output logic                         o_log_valid,
   output logic [rr_pkg::REC_W-1:0]     o_log_data,
   input  logic                         i_log_ready
);

   import rr_pkg::*;

   // Channel arrays, indexed by CH_*
   logic [NUM_CH-1:0]        src_valid;
   logic [NUM_CH-1:0]        src_ready;
   logic [CH_MAX_W-1:0]      src_data [NUM_CH];
   logic [NUM_CH-1:0]        dst_valid;
   logic [NUM_CH-1:0]        dst_ready;
   logic [CH_MAX_W-1:0]      dst_data [NUM_CH];

   // Log path
   logic [NUM_CH-1:0]        logb_valid;
   logic [REC_PAYLOAD_W-1:0] logb_data;
   logic                     rec_valid;
   logic [REC_W-1:0]         rec_data;
   logic [$clog2(LOG_DEPTH):0] log_count;
   logic                     log_stall;

   // AW, W and AR flow master to slave
   assign src_valid[CH_AW] = i_m_awvalid;
   assign src_data[CH_AW]  = CH_MAX_W'({i_m_awid, i_m_awaddr, i_m_awlen, i_m_awsize});
   assign o_m_awready      = src_ready[CH_AW];
   assign o_s_awvalid      = dst_valid[CH_AW];
   assign dst_ready[CH_AW] = i_s_awready;
   assign {o_s_awid, o_s_awaddr, o_s_awlen, o_s_awsize} = dst_data[CH_AW][AW_W-1:0];

   assign src_valid[CH_W]  = i_m_wvalid;
   assign src_data[CH_W]   = CH_MAX_W'({i_m_wid, i_m_wdata, i_m_wstrb, i_m_wlast});
   assign o_m_wready       = src_ready[CH_W];
   assign o_s_wvalid       = dst_valid[CH_W];
   assign dst_ready[CH_W]  = i_s_wready;
   assign {o_s_wid, o_s_wdata, o_s_wstrb, o_s_wlast} = dst_data[CH_W][W_W-1:0];

   assign src_valid[CH_AR] = i_m_arvalid;
   assign src_data[CH_AR]  = CH_MAX_W'({i_m_arid, i_m_araddr, i_m_arlen, i_m_arsize});
   assign o_m_arready      = src_ready[CH_AR];
   assign o_s_arvalid      = dst_valid[CH_AR];
   assign dst_ready[CH_AR] = i_s_arready;
   assign {o_s_arid, o_s_araddr, o_s_arlen, o_s_arsize} = dst_data[CH_AR][AR_W-1:0];

   // B and R flow slave to master
   assign src_valid[CH_B]  = i_s_bvalid;
   assign src_data[CH_B]   = CH_MAX_W'({i_s_bid, i_s_bresp});
   assign o_s_bready       = src_ready[CH_B];
   assign o_m_bvalid       = dst_valid[CH_B];
   assign dst_ready[CH_B]  = i_m_bready;
   assign {o_m_bid, o_m_bresp} = dst_data[CH_B][B_W-1:0];

   assign src_valid[CH_R]  = i_s_rvalid;
   assign src_data[CH_R]   = CH_MAX_W'({i_s_rid, i_s_rdata, i_s_rresp, i_s_rlast});
   assign o_s_rready       = src_ready[CH_R];
   assign o_m_rvalid       = dst_valid[CH_R];
   assign dst_ready[CH_R]  = i_m_rready;
   assign {o_m_rid, o_m_rdata, o_m_rresp, o_m_rlast} = dst_data[CH_R][R_W-1:0];

   // One logger per channel, each writing its own record slot
   for (genvar g = 0; g < NUM_CH; g++) begin : gen_logger
      localparam int WIDTH = CH_WIDTHS[g];

      logic [WIDTH-1:0] out_data;

      axi_channel_logger #(
         .WIDTH(WIDTH)
      ) logger_i (
         .clk         (clk),
         .i_rst       (i_rst),
         .i_in_valid  (src_valid[g]),
         .i_in_data   (src_data[g][WIDTH-1:0]),
         .o_in_ready  (src_ready[g]),
         .o_out_valid (dst_valid[g]),
         .o_out_data  (out_data),
         .i_out_ready (dst_ready[g]),
         .o_logb_valid(logb_valid[g]),
         .o_logb_data (logb_data[CH_OFFSETS[g] +: WIDTH]),
         .i_stall     (log_stall)
      );

      assign dst_data[g] = CH_MAX_W'(out_data);
   end

   log_record_packer packer_i (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_logb_valid(logb_valid),
      .i_logb_data (logb_data),
      .o_rec_valid (rec_valid),
      .o_rec_data  (rec_data)
   );

   log_fifo #(
      .LOG_DEPTH(LOG_DEPTH)
   ) fifo_i (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_wr_valid(rec_valid),
      .i_wr_data (rec_data),
      .o_rd_valid(o_log_valid),
      .o_rd_data (o_log_data),
      .i_rd_ready(i_log_ready),
      .o_count   (log_count)
   );

   // Stall every channel while the log backs up
   log_flow_ctrl #(
      .LOG_DEPTH(LOG_DEPTH)
   ) flow_ctrl_i (
      .clk    (clk),
      .i_rst  (i_rst),
      .i_count(log_count),
      .o_stall(log_stall)
   );

endmodule

//--- tests/tb_axi_recorder.sv
`timescale 1ns/1ns

module tb_axi_recorder;

   import rr_pkg::*;

   localparam int LOG_DEPTH      = 16;
   localparam int CLK_PERIOD     = 20;
   localparam int NUM_BEATS      = 300;
   localparam int HOLD_START     = 200;
   localparam int HOLD_CYCLES    = 200;
   localparam int TIMEOUT_CYCLES = NUM_BEATS * NUM_CH * 40 + 1000;

   logic clk, i_rst, i_log_ready, o_log_valid;
   logic i_m_awvalid, i_m_wvalid, i_m_arvalid, i_m_bready, i_m_rready;
   logic i_s_awready, i_s_wready, i_s_arready, i_s_bvalid, i_s_rvalid;
   logic o_m_awready, o_m_wready, o_m_arready, o_m_bvalid, o_m_rvalid;
   logic o_s_awvalid, o_s_wvalid, o_s_arvalid, o_s_bready, o_s_rready;
   logic i_m_wlast, i_s_rlast, o_m_rlast, o_s_wlast;
   logic [ID_W-1:0]   i_m_awid, i_m_wid, i_m_arid, i_s_bid, i_s_rid;
   logic [ID_W-1:0]   o_s_awid, o_s_wid, o_s_arid, o_m_bid, o_m_rid;
   logic [ADDR_W-1:0] i_m_awaddr, i_m_araddr, o_s_awaddr, o_s_araddr;
   logic [LEN_W-1:0]  i_m_awlen, i_m_arlen, o_s_awlen, o_s_arlen;
   logic [SIZE_W-1:0] i_m_awsize, i_m_arsize, o_s_awsize, o_s_arsize;
   logic [DATA_W-1:0] i_m_wdata, i_s_rdata, o_s_wdata, o_m_rdata;
   logic [STRB_W-1:0] i_m_wstrb, o_s_wstrb;
   logic [RESP_W-1:0] i_s_bresp, i_s_rresp, o_m_bresp, o_m_rresp;
   logic [REC_W-1:0]  o_log_data;

   // Per-channel views indexed by CH_*
   logic [NUM_CH-1:0]   src_valid;
   logic [NUM_CH-1:0]   src_ready;
   logic [NUM_CH-1:0]   src_fire;
   logic [CH_MAX_W-1:0] src_data [NUM_CH];
   logic [NUM_CH-1:0]   dst_valid;
   logic [NUM_CH-1:0]   dst_ready;
   logic [CH_MAX_W-1:0] dst_data [NUM_CH];
   string               dst_name [NUM_CH] = '{"o_s_aw", "o_s_w", "o_s_ar", "o_m_b", "o_m_r"};

   // Reference model
   logic [CH_MAX_W-1:0] chq [NUM_CH][$];
   logic [REC_W-1:0]    recq [$];
   int                  started [NUM_CH];
   int                  fired_total;
   int                  value_errors;
   int                  other_errors;
   logic                saw_stall;
   logic [63:0]         rng_state;

   axi_recorder_top #(.LOG_DEPTH(LOG_DEPTH)) dut_i (.*);

   // Fields packed in channel order with id first
   assign {i_s_rvalid, i_s_bvalid, i_m_arvalid, i_m_wvalid, i_m_awvalid} = src_valid;
   assign {i_m_awid, i_m_awaddr, i_m_awlen, i_m_awsize} = src_data[CH_AW][AW_W-1:0];
   assign {i_m_wid, i_m_wdata, i_m_wstrb, i_m_wlast}    = src_data[CH_W][W_W-1:0];
   assign {i_m_arid, i_m_araddr, i_m_arlen, i_m_arsize} = src_data[CH_AR][AR_W-1:0];
   assign {i_s_bid, i_s_bresp}                          = src_data[CH_B][B_W-1:0];
   assign {i_s_rid, i_s_rdata, i_s_rresp, i_s_rlast}    = src_data[CH_R][R_W-1:0];
   assign src_ready = {o_s_rready, o_s_bready, o_m_arready, o_m_wready, o_m_awready};
   assign dst_valid = {o_m_rvalid, o_m_bvalid, o_s_arvalid, o_s_wvalid, o_s_awvalid};
   assign {i_m_rready, i_m_bready, i_s_arready, i_s_wready, i_s_awready} = dst_ready;
   assign dst_data[CH_AW] = CH_MAX_W'({o_s_awid, o_s_awaddr, o_s_awlen, o_s_awsize});
   assign dst_data[CH_W]  = CH_MAX_W'({o_s_wid, o_s_wdata, o_s_wstrb, o_s_wlast});
   assign dst_data[CH_AR] = CH_MAX_W'({o_s_arid, o_s_araddr, o_s_arlen, o_s_arsize});
   assign dst_data[CH_B]  = CH_MAX_W'({o_m_bid, o_m_bresp});
   assign dst_data[CH_R]  = CH_MAX_W'({o_m_rid, o_m_rdata, o_m_rresp, o_m_rlast});

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   function automatic logic [63:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 7);
      rng_state = rng_state ^ (rng_state << 17);
      return rng_state;
   endfunction

   function automatic logic [CH_MAX_W-1:0] width_mask(int ch);
      return (CH_MAX_W'(1) << CH_WIDTHS[ch]) - CH_MAX_W'(1);
   endfunction

   task automatic check_value(input string name, input logic [REC_W-1:0] exp_val,
                              input logic [REC_W-1:0] act_val);
      assert (act_val === exp_val) else begin
         value_errors++;
         $display("FAIL %0t %s expected %h got %h", $time, name, exp_val, act_val);
      end
   endtask

   // Handshakes seen here complete at the next rising edge
   task automatic sample_cycle(input bit idle_check, input bit log_hold);
      logic [REC_W-1:0]    rec;
      logic [CH_MAX_W-1:0] beat;
      rec = '0;
      if (idle_check) begin
         check_value("dst_valid", '0, REC_W'(dst_valid));
         check_value("o_log_valid", '0, REC_W'(o_log_valid));
         check_value("src_ready", REC_W'({NUM_CH{1'b1}}), REC_W'(src_ready));
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
         if (dst_valid[ch] && dst_ready[ch]) begin
            assert (chq[ch].size() > 0) else begin
               other_errors++;
               $display("Transfer at %0t on %s with no matching source beat", $time, dst_name[ch]);
            end
            if (chq[ch].size() > 0) begin
               beat = chq[ch].pop_front();
               check_value({dst_name[ch], " payload"}, REC_W'(beat), REC_W'(dst_data[ch]));
            end
         end
      end
      if (o_log_valid && i_log_ready) begin
         assert (recq.size() > 0) else begin
            other_errors++;
            $display("Log record at %0t with no expected record left", $time);
         end
         if (recq.size() > 0) begin
            check_value("o_log_data", recq.pop_front(), o_log_data);
         end
      end
      // Every beat accepted at this edge lands in one record
      for (int ch = 0; ch < NUM_CH; ch++) begin
         src_fire[ch] = src_valid[ch] && src_ready[ch];
         if (src_fire[ch]) begin
            chq[ch].push_back(src_data[ch]);
            rec[REC_MAP_LSB + ch] = 1'b1;
            rec = rec | (REC_W'(src_data[ch]) << CH_OFFSETS[ch]);
            fired_total++;
         end
      end
      if (|src_fire) begin
         recq.push_back(rec);
      end
      // With every destination ready only the stall can hold the readies low
      if (log_hold && dst_ready == '1 && src_ready == '0) begin
         saw_stall = 1'b1;
      end
   endtask

   task automatic run_cycle(input bit traffic, input bit log_hold, input bit idle_check);
      logic [63:0] r;
      @(negedge clk);
      for (int ch = 0; ch < NUM_CH; ch++) begin
         r = next_random();
         if (src_fire[ch]) begin
            src_valid[ch] = 1'b0;
         end
         // New beat only once the previous one is gone
         if (traffic && !src_valid[ch] && started[ch] < NUM_BEATS && r[0]) begin
            src_valid[ch] = 1'b1;
            src_data[ch]  = CH_MAX_W'(r >> 8) & width_mask(ch);
            started[ch]++;
         end
         dst_ready[ch] = !traffic || (r[3:2] != 2'b00);
      end
      r = next_random();
      i_log_ready = !log_hold && (!traffic || r[1:0] != 2'b00);
      #(CLK_PERIOD / 4);
      sample_cycle(idle_check, log_hold);
   endtask

   initial begin
      int cycle;
      int idle_run;
      rng_state    = 64'd18;
      i_rst        = 1'b1;
      i_log_ready  = 1'b0;
      src_valid    = '0;
      src_fire     = '0;
      dst_ready    = '0;
      src_data     = '{default: '0};
      started      = '{default: 0};
      fired_total  = 0;
      value_errors = 0;
      other_errors = 0;
      saw_stall    = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      repeat (10) run_cycle(1'b0, 1'b0, 1'b1);
      // Random traffic with one long log stall in the middle
      cycle = 0;
      while (fired_total < NUM_BEATS * NUM_CH) begin
         run_cycle(1'b1, cycle >= HOLD_START && cycle < HOLD_START + HOLD_CYCLES, 1'b0);
         cycle++;
      end
      idle_run = 0;
      while (idle_run < 4) begin
         run_cycle(1'b0, 1'b0, 1'b0);
         idle_run = (dst_valid == '0 && !o_log_valid) ? idle_run + 1 : 0;
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
         assert (chq[ch].size() == 0) else begin
            other_errors++;
            $display("%0d beats never reached %s", chq[ch].size(), dst_name[ch]);
         end
      end
      assert (recq.size() == 0) else begin
         other_errors++;
         $display("%0d expected log records never appeared", recq.size());
      end
      assert (saw_stall) else begin
         other_errors++;
         $display("Source readies never dropped while the log port was held");
      end
      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles, traffic or log never drained", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

endmodule

//--- all.f
source/rr_pkg.sv
source/axi_channel_logger.sv
source/log_flow_ctrl.sv
source/log_record_packer.sv
source/log_fifo.sv
source/axi_recorder_top.sv
tests/tb_axi_recorder.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_axi_recorder \
   -f all.f -o tb_axi_recorder > build.log 2>&1 \
   && ./obj_dir/tb_axi_recorder > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
